// ==== bench/tb_tasks.svh ====
// Transmit FIFO bench tasks
// source driver, MAC model and compares

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ----------------------------------------------------------------------------
// compares
// ----------------------------------------------------------------------------

task automatic check_byte(input tx_fifo_pkg::byte_t got, input tx_fifo_pkg::byte_t exp,
                          input string what);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
  end
endtask

task automatic check_status(input logic [tx_fifo_pkg::STATUS_W-1:0] got,
                            input logic [tx_fifo_pkg::STATUS_W-1:0] exp,
                            input string what);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

// ----------------------------------------------------------------------------
// local-link source
// ----------------------------------------------------------------------------

// random payload, queued for the source and, unless dropped, for the MAC
task automatic queue_frame(input int len, input bit expect_out);
  tx_fifo_pkg::byte_t b;
  for (int i = 0; i < len; i++) begin
    b = tx_fifo_pkg::byte_t'($urandom);
    wr_stream.push_back({(i == len - 1), (i == 0), b});
    if (expect_out) begin
      exp_bytes.push_back(b);
    end
  end
  if (expect_out) begin
    exp_lens.push_back(len);
  end
endtask

// sends every queued word with no gaps, waits out wr_dst_rdy_n
task automatic push_stream();
  logic [9:0] w;
  while (wr_stream.size() > 0) begin
    w            = wr_stream[0];
    wr_data      = w[7:0];
    wr_sof_n     = !w[8];
    wr_eof_n     = !w[9];
    wr_src_rdy_n = 1'b0;
    @(negedge wr_clk);
    ovf_seen   = ovf_seen | overflow;
    valid_seen = valid_seen | tx_data_valid;
    // transfer happens on the coming edge
    if (!wr_dst_rdy_n) begin
      w = wr_stream.pop_front();
    end
    @(posedge wr_clk);
    #1;
  end
  wr_src_rdy_n = 1'b1;
  wr_sof_n     = 1'b1;
  wr_eof_n     = 1'b1;
endtask

task automatic idle_cycles(input int n);
  repeat (n) begin
    @(negedge wr_clk);
    ovf_seen   = ovf_seen | overflow;
    valid_seen = valid_seen | tx_data_valid;
    @(posedge wr_clk);
    #1;
  end
endtask

// ----------------------------------------------------------------------------
// MAC model
// ----------------------------------------------------------------------------

// one clock, enable set first, outputs sampled mid-cycle
task automatic mac_cycle(input bit toggle, output logic en, output logic valid,
                         output tx_fifo_pkg::byte_t data);
  if (toggle) begin
    rd_enable = ($urandom % 2) != 0;
  end else begin
    rd_enable = 1'b1;
  end
  @(negedge wr_clk);
  en    = rd_enable;
  valid = tx_data_valid;
  data  = tx_data;
  // nothing moves after a disabled cycle
  if (!prev_en) begin
    check_flag(valid, prev_valid, "tx_data_valid hold while disabled");
    check_byte(data, prev_data, "tx_data hold while disabled");
  end
  prev_en    = en;
  prev_valid = valid;
  prev_data  = data;
  @(posedge wr_clk);
  #1;
endtask

task automatic wait_for_valid(input bit toggle);
  logic               en;
  logic               valid;
  tx_fifo_pkg::byte_t data;
  int                 n;
  n     = 0;
  valid = 1'b0;
  while (!valid && n < 300) begin
    mac_cycle(toggle, en, valid, data);
    n++;
  end
  if (!valid) begin
    err_cnt++;
    $display("tx_data_valid did not rise within 300 cycles at %0t ns", $time);
  end
endtask

// ack after ack_delay cycles, then collect and compare the whole frame
task automatic receive_frame(input int ack_delay, input bit toggle);
  int                 len;
  int                 got;
  logic               en;
  logic               valid;
  tx_fifo_pkg::byte_t data;
  tx_fifo_pkg::byte_t first;
  len   = exp_lens.pop_front();
  first = exp_bytes[0];
  wait_for_valid(toggle);
  // first byte parked on the output while ack is held off
  for (int i = 0; i < ack_delay; i++) begin
    mac_cycle(toggle, en, valid, data);
    check_flag(valid, 1'b1, "tx_data_valid before ack");
    check_byte(data, first, "tx_data before ack");
  end
  tx_ack = 1'b1;
  got    = 0;
  // ack edge takes the first byte, then one byte per enabled cycle
  while (got < len) begin
    mac_cycle(toggle, en, valid, data);
    if (en) begin
      check_flag(valid, 1'b1, "tx_data_valid in frame");
      check_byte(data, exp_bytes.pop_front(), "tx_data");
      got++;
      tx_ack = 1'b0;
    end
  end
  tx_ack = 1'b0;
  // valid must be down on the next enabled cycle
  en = 1'b0;
  while (!en) begin
    mac_cycle(toggle, en, valid, data);
  end
  check_flag(valid, 1'b0, "tx_data_valid after eof byte");
  rd_enable = 1'b1;
endtask

`endif

// ==== bench/tb_tx_client_fifo.sv ====
// Transmit client FIFO testbench
// directed frame tests against a simple MAC model

`timescale 1ns/1ns

module tb_tx_client_fifo;

  // frame lengths of the directed tests
  localparam int LEN_SINGLE = 60;
  localparam int LEN_ACK    = 64;
  localparam int LEN_B2B_A  = 50;
  localparam int LEN_B2B_B  = 70;
  localparam int LEN_B2B_C  = 90;
  localparam int LEN_TOGGLE = 120;
  localparam int LEN_STATUS = 200;
  localparam int LEN_DROP   = 600;
  localparam int LEN_AFTER  = 40;

  // four cycles of slack per byte, plus reset, ack waits and drains
  localparam int CYCLE_LIMIT = (LEN_SINGLE + LEN_ACK + LEN_B2B_A + LEN_B2B_B + LEN_B2B_C +
                                LEN_TOGGLE + LEN_STATUS + LEN_DROP + LEN_AFTER) * 4 + 2000;

  // DUT ports
  logic                             wr_clk;
  logic                             wr_sreset;
  tx_fifo_pkg::byte_t               wr_data;
  logic                             wr_sof_n;
  logic                             wr_eof_n;
  logic                             wr_src_rdy_n;
  logic                             wr_dst_rdy_n;
  logic [tx_fifo_pkg::STATUS_W-1:0] wr_fifo_status;
  logic                             rd_enable;
  tx_fifo_pkg::byte_t               tx_data;
  logic                             tx_data_valid;
  logic                             tx_ack;
  logic                             overflow;

  // pending input words, {eof, sof, byte}
  logic [9:0]         wr_stream [$];
  // bytes and lengths the MAC should see, in order
  tx_fifo_pkg::byte_t exp_bytes [$];
  int                 exp_lens [$];

  int                 err_cnt;
  int                 check_cnt;
  int                 cycle_cnt;
  int unsigned        seed_draw;

  // previous MAC sample, for the hold check on disabled cycles
  logic               prev_en;
  logic               prev_valid;
  tx_fifo_pkg::byte_t prev_data;

  // sticky flags seen while pushing input or idling
  logic               ovf_seen;
  logic               valid_seen;

  tx_client_fifo u_dut (
    .wr_clk         (wr_clk),
    .wr_sreset      (wr_sreset),
    .wr_data        (wr_data),
    .wr_sof_n       (wr_sof_n),
    .wr_eof_n       (wr_eof_n),
    .wr_src_rdy_n   (wr_src_rdy_n),
    .wr_dst_rdy_n   (wr_dst_rdy_n),
    .wr_fifo_status (wr_fifo_status),
    .rd_enable      (rd_enable),
    .tx_data        (tx_data),
    .tx_data_valid  (tx_data_valid),
    .tx_ack         (tx_ack),
    .overflow       (overflow)
  );

  // 10 ns clock
  always #5 wr_clk = ~wr_clk;

  `include "tb_tasks.svh"

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic single_frame();
    queue_frame(LEN_SINGLE, 1'b1);
    push_stream();
    receive_frame(2, 1'b0);
  endtask

  // first byte must sit on the output until the late ack
  task automatic delayed_ack();
    int delay;
    delay = $urandom_range(40, 5);
    queue_frame(LEN_ACK, 1'b1);
    push_stream();
    receive_frame(delay, 1'b0);
  endtask

  // each sof right on the cycle after the previous eof
  task automatic back_to_back();
    queue_frame(LEN_B2B_A, 1'b1);
    queue_frame(LEN_B2B_B, 1'b1);
    queue_frame(LEN_B2B_C, 1'b1);
    push_stream();
    receive_frame(1, 1'b0);
    receive_frame(1, 1'b0);
    receive_frame(1, 1'b0);
  endtask

  task automatic enable_toggle();
    queue_frame(LEN_TOGGLE, 1'b1);
    push_stream();
    receive_frame(3, 1'b1);
  endtask

  task automatic status_level();
    int                               level;
    logic [tx_fifo_pkg::STATUS_W-1:0] exp_status;
    queue_frame(LEN_STATUS, 1'b1);
    push_stream();
    // frame parked in WAIT_ACK with four entries already fetched
    wait_for_valid(1'b0);
    idle_cycles(3);
    level = (LEN_STATUS - 4) / (tx_fifo_pkg::DEPTH / 16);
    exp_status = level[tx_fifo_pkg::STATUS_W-1:0];
    check_status(wr_fifo_status, exp_status, "status with frame parked");
    receive_frame(2, 1'b0);
    idle_cycles(4);
    check_status(wr_fifo_status, '0, "status after drain");
  endtask

  // oversize frame with nothing stored gets dropped, the next one survives
  task automatic overflow_drop();
    ovf_seen   = 1'b0;
    valid_seen = 1'b0;
    queue_frame(LEN_DROP, 1'b0);
    push_stream();
    idle_cycles(30);
    check_flag(ovf_seen, 1'b1, "overflow during oversize frame");
    check_flag(valid_seen, 1'b0, "tx_data_valid for dropped frame");
    check_flag(overflow, 1'b0, "overflow after drop");
    queue_frame(LEN_AFTER, 1'b1);
    push_stream();
    receive_frame(3, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // run sequence
  // --------------------------------------------------------------------------

  initial begin
    seed_draw    = $urandom(38655);
    err_cnt      = 0;
    check_cnt    = 0;
    prev_en      = 1'b1;
    prev_valid   = 1'b0;
    prev_data    = '0;
    ovf_seen     = 1'b0;
    valid_seen   = 1'b0;
    wr_clk       = 1'b0;
    wr_sreset    = 1'b1;
    wr_data      = '0;
    wr_sof_n     = 1'b1;
    wr_eof_n     = 1'b1;
    wr_src_rdy_n = 1'b1;
    rd_enable    = 1'b1;
    tx_ack       = 1'b0;
    repeat (4) @(posedge wr_clk);
    #1;
    wr_sreset = 1'b0;
    idle_cycles(2);
    single_frame();
    delayed_ack();
    back_to_back();
    enable_toggle();
    status_level();
    overflow_drop();
    idle_cycles(4);
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge wr_clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
             CYCLE_LIMIT, err_cnt);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== logic/frame_reader.sv ====
// Transmit FIFO read side
// prefetch, ack handshake and MAC byte stream

`timescale 1ns/1ns

module frame_reader (
  input  logic                wr_clk,
  input  logic                wr_sreset,
  input  logic                rd_enable,
  input  logic                tx_ack,
  input  logic                frame_in_fifo,
  input  tx_fifo_pkg::entry_t rd_entry,
  output logic                rd_en,
  output logic                frame_sent,
  output logic                tx_data_valid,
  output tx_fifo_pkg::addr_t  rd_addr,
  output tx_fifo_pkg::byte_t  tx_data
);

  tx_fifo_pkg::rd_state_t rd_state;
  tx_fifo_pkg::rd_state_t rd_nxt_state;

  logic               rd_fetch;
  logic               rd_reload;
  tx_fifo_pkg::addr_t rd_dec_addr;

  // two stages behind the memory output register
  tx_fifo_pkg::byte_t data_pipe [0:1];
  // eof travels beside the data, [1] lines up with data_pipe[1]
  logic [1:0]         eof_pipe;

  // ------------------------------------------------------------------------
  // read FSM, advances only on MAC clock enable
  // ------------------------------------------------------------------------

  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      rd_state <= tx_fifo_pkg::IDLE_S;
    end else if (rd_enable) begin
      rd_state <= rd_nxt_state;
    end
  end

  always_comb begin
    rd_nxt_state = rd_state;
    case (rd_state)
      tx_fifo_pkg::IDLE_S: begin
        if (frame_in_fifo) begin
          rd_nxt_state = tx_fifo_pkg::QUEUE1_S;
        end
      end
      // fill memory register and both pipe stages
      tx_fifo_pkg::QUEUE1_S: begin
        rd_nxt_state = tx_fifo_pkg::QUEUE2_S;
      end
      tx_fifo_pkg::QUEUE2_S: begin
        rd_nxt_state = tx_fifo_pkg::QUEUE3_S;
      end
      tx_fifo_pkg::QUEUE3_S: begin
        rd_nxt_state = tx_fifo_pkg::QUEUE_ACK_S;
      end
      // first byte goes to the output here
      tx_fifo_pkg::QUEUE_ACK_S: begin
        rd_nxt_state = tx_fifo_pkg::WAIT_ACK_S;
      end
      tx_fifo_pkg::WAIT_ACK_S: begin
        if (tx_ack) begin
          rd_nxt_state = tx_fifo_pkg::FRAME_S;
        end
      end
      tx_fifo_pkg::FRAME_S: begin
        if (eof_pipe[1]) begin
          rd_nxt_state = tx_fifo_pkg::IDLE_S;
        end
      end
      default: begin
        rd_nxt_state = tx_fifo_pkg::IDLE_S;
      end
    endcase
  end

  // ------------------------------------------------------------------------
  // control decode
  // ------------------------------------------------------------------------

  // fetch in every busy state, except while stalled on the ack
  assign rd_fetch = (rd_state != tx_fifo_pkg::IDLE_S) &&
                    ((rd_nxt_state == tx_fifo_pkg::FRAME_S) ||
                     (rd_state != tx_fifo_pkg::WAIT_ACK_S));

  assign rd_en = rd_enable && rd_fetch;

  assign rd_reload = (rd_state == tx_fifo_pkg::FRAME_S) &&
                     (rd_nxt_state == tx_fifo_pkg::IDLE_S);

  // one enabled cycle per frame, counted out by the tracker
  assign frame_sent = rd_enable && (rd_state == tx_fifo_pkg::WAIT_ACK_S) &&
                      (rd_nxt_state == tx_fifo_pkg::FRAME_S);

  // ------------------------------------------------------------------------
  // read address
  // ------------------------------------------------------------------------

  // when eof reaches the last stage, rd_dec_addr is one past it,
  // which throws away the entries fetched beyond the frame
  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      rd_addr     <= '0;
      rd_dec_addr <= '0;
    end else if (rd_enable) begin
      if (rd_reload) begin
        rd_addr <= rd_dec_addr;
      end else if (rd_fetch) begin
        rd_addr <= rd_addr + 1'b1;
      end
      if (rd_fetch) begin
        rd_dec_addr <= rd_addr - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // prefetch pipe
  // ------------------------------------------------------------------------

  always_ff @(posedge wr_clk) begin
    if (rd_en) begin
      data_pipe[0] <= rd_entry[tx_fifo_pkg::DATA_W-1:0];
      data_pipe[1] <= data_pipe[0];
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      eof_pipe <= '0;
    end else if (rd_en) begin
      eof_pipe <= {eof_pipe[0], rd_entry[tx_fifo_pkg::DATA_W]};
    end
  end

  // ------------------------------------------------------------------------
  // MAC outputs
  // ------------------------------------------------------------------------

  // byte held in WAIT_ACK, streamed in FRAME including the eof byte
  always_ff @(posedge wr_clk) begin
    if (rd_enable) begin
      if (rd_nxt_state == tx_fifo_pkg::FRAME_S ||
          rd_state == tx_fifo_pkg::QUEUE_ACK_S ||
          rd_state == tx_fifo_pkg::FRAME_S) begin
        tx_data <= data_pipe[1];
      end else if (rd_state != tx_fifo_pkg::WAIT_ACK_S) begin
        tx_data <= '0;
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      tx_data_valid <= 1'b0;
    end else if (rd_enable) begin
      tx_data_valid <= (rd_nxt_state == tx_fifo_pkg::FRAME_S) ||
                       (rd_state == tx_fifo_pkg::QUEUE_ACK_S) ||
                       (rd_state == tx_fifo_pkg::WAIT_ACK_S) ||
                       (rd_state == tx_fifo_pkg::FRAME_S);
    end
  end

  // valid stays up from the first byte until the eof byte has gone out
  a_valid_in_frame: assert property (@(posedge wr_clk) disable iff (wr_sreset)
    (rd_state == tx_fifo_pkg::WAIT_ACK_S || rd_state == tx_fifo_pkg::FRAME_S)
      |-> tx_data_valid);

endmodule

// ==== logic/frame_store_ram.sv ====
// Transmit FIFO frame memory
// simple dual-port, byte plus eof per entry

`timescale 1ns/1ns

module frame_store_ram (
  input  logic                wr_clk,
  input  logic                wr_en,
  input  logic                rd_en,
  input  tx_fifo_pkg::addr_t  wr_addr,
  input  tx_fifo_pkg::addr_t  rd_addr,
  input  tx_fifo_pkg::entry_t wr_entry,
  output tx_fifo_pkg::entry_t rd_entry
);

  tx_fifo_pkg::entry_t mem [tx_fifo_pkg::DEPTH];

  // write port
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_entry;
    end
  end

  // registered read, holds its output while rd_en is low
  always_ff @(posedge wr_clk) begin
    if (rd_en) begin
      rd_entry <= mem[rd_addr];
    end
  end

endmodule

// ==== logic/frame_writer.sv ====
// Transmit FIFO write side
// local-link input pipe, write FSM and overflow drop

`timescale 1ns/1ns

module frame_writer (
  input  logic                wr_clk,
  input  logic                wr_sreset,
  input  tx_fifo_pkg::byte_t  wr_data,
  input  logic                wr_sof_n,
  input  logic                wr_eof_n,
  input  logic                wr_src_rdy_n,
  input  logic                fifo_full,
  input  logic                frame_in_fifo,
  output logic                wr_dst_rdy_n,
  output logic                overflow,
  output logic                wr_en,
  output logic                frame_stored,
  output tx_fifo_pkg::addr_t  wr_addr,
  output tx_fifo_pkg::entry_t wr_entry
);

  tx_fifo_pkg::wr_state_t wr_state;
  tx_fifo_pkg::wr_state_t wr_nxt_state;

  // input pipe, stage 0 samples every cycle, stage 1 only on accept
  tx_fifo_pkg::byte_t data_pipe [0:1];
  logic [1:0]         sof_pipe;
  logic [1:0]         eof_pipe;
  logic [1:0]         accept_pipe;
  logic               accept_mem;
  logic               entry_eof;

  logic               ovflow_hold;
  logic               eof_state_reg;
  logic               fifo_overflow;
  logic               start_addr_load;
  tx_fifo_pkg::addr_t start_addr;

  // ------------------------------------------------------------------------
  // input pipeline
  // ------------------------------------------------------------------------

  // byte path, three registers from transfer to memory port
  always_ff @(posedge wr_clk) begin
    data_pipe[0] <= wr_data;
    if (accept_pipe[0]) begin
      data_pipe[1] <= data_pipe[0];
    end
    if (accept_pipe[1]) begin
      wr_entry <= {eof_pipe[1], data_pipe[1]};
    end
  end

  // framing flags and accept strobes steer the FSM
  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      accept_pipe <= '0;
      accept_mem  <= 1'b0;
      sof_pipe    <= '0;
      eof_pipe    <= '0;
    end else begin
      accept_pipe[0] <= !wr_src_rdy_n && !wr_dst_rdy_n;
      accept_pipe[1] <= accept_pipe[0];
      accept_mem     <= accept_pipe[1];
      sof_pipe[0]    <= !wr_sof_n;
      eof_pipe[0]    <= !wr_eof_n;
      if (accept_pipe[0]) begin
        sof_pipe[1] <= sof_pipe[0];
        eof_pipe[1] <= eof_pipe[0];
      end
    end
  end

  // eof flag of the entry at the memory port
  assign entry_eof = wr_entry[tx_fifo_pkg::DATA_W];

  // ------------------------------------------------------------------------
  // write FSM
  // ------------------------------------------------------------------------

  // memory has run out with nothing to drain it
  // blocked around eof, where the frame count is still catching up
  assign fifo_overflow = fifo_full && !frame_in_fifo &&
                         (wr_state != tx_fifo_pkg::EOF_S) && !eof_state_reg;

  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      wr_state <= tx_fifo_pkg::WAIT_S;
    end else begin
      wr_state <= wr_nxt_state;
    end
  end

  always_comb begin
    wr_nxt_state = wr_state;
    case (wr_state)
      tx_fifo_pkg::WAIT_S: begin
        if (sof_pipe[1]) begin
          wr_nxt_state = tx_fifo_pkg::DATA_S;
        end
      end
      tx_fifo_pkg::DATA_S: begin
        // no drop once the eof is already in the pipe
        if (fifo_overflow && !eof_pipe[0] && !eof_pipe[1]) begin
          wr_nxt_state = tx_fifo_pkg::OVFLOW_S;
        end else if (eof_pipe[1]) begin
          wr_nxt_state = tx_fifo_pkg::EOF_S;
        end
      end
      tx_fifo_pkg::EOF_S: begin
        // sof right behind the eof, back-to-back frame
        if (sof_pipe[1]) begin
          wr_nxt_state = tx_fifo_pkg::DATA_S;
        end else if (entry_eof) begin
          wr_nxt_state = tx_fifo_pkg::WAIT_S;
        end
      end
      tx_fifo_pkg::OVFLOW_S: begin
        // swallow the rest of the dropped frame
        if (entry_eof) begin
          wr_nxt_state = tx_fifo_pkg::WAIT_S;
        end
      end
      default: begin
        wr_nxt_state = tx_fifo_pkg::WAIT_S;
      end
    endcase
  end

  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      eof_state_reg <= 1'b0;
      frame_stored  <= 1'b0;
    end else begin
      eof_state_reg <= (wr_state == tx_fifo_pkg::EOF_S);
      frame_stored  <= start_addr_load;
    end
  end

  // ------------------------------------------------------------------------
  // outputs and flow control
  // ------------------------------------------------------------------------

  assign overflow = (wr_state == tx_fifo_pkg::OVFLOW_S);
  assign wr_en    = accept_mem && !overflow;

  // in overflow keep accepting until the dropped frame's eof is in,
  // then hold off the source until the FSM is back in WAIT
  assign wr_dst_rdy_n = overflow ? ovflow_hold : fifo_full;

  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      ovflow_hold <= 1'b0;
    end else if (!wr_eof_n && !wr_src_rdy_n && !wr_dst_rdy_n) begin
      ovflow_hold <= 1'b1;
    end else if (fifo_overflow && wr_state == tx_fifo_pkg::DATA_S) begin
      ovflow_hold <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // write address
  // ------------------------------------------------------------------------

  // next frame begins one past the committed eof
  assign start_addr_load = (wr_state == tx_fifo_pkg::EOF_S) &&
                           (wr_nxt_state != tx_fifo_pkg::EOF_S);

  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      start_addr <= '0;
    end else if (start_addr_load) begin
      start_addr <= wr_addr + 1'b1;
    end
  end

  // rewind held for the whole overflow
  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      wr_addr <= '0;
    end else if (overflow) begin
      wr_addr <= start_addr;
    end else if (wr_en) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  // no tail entry of a dropped frame leaks out once overflow ends
  a_ovflow_no_write: assert property (@(posedge wr_clk) disable iff (wr_sreset)
    overflow |=> !wr_en);

endmodule

// ==== logic/occupancy_tracker.sv ====
// Transmit FIFO occupancy
// frame count, full flag and status

`timescale 1ns/1ns

module occupancy_tracker (
  input  logic                            wr_clk,
  input  logic                            wr_sreset,
  input  logic                            frame_stored,
  input  logic                            frame_sent,
  input  tx_fifo_pkg::addr_t              wr_addr,
  input  tx_fifo_pkg::addr_t              rd_addr,
  output logic                            frame_in_fifo,
  output logic                            fifo_full,
  output logic [tx_fifo_pkg::STATUS_W-1:0] wr_fifo_status
);

  tx_fifo_pkg::frame_cnt_t frame_cnt;
  tx_fifo_pkg::frame_cnt_t frame_cnt_nxt;
  tx_fifo_pkg::addr_t      occ_raw;
  tx_fifo_pkg::addr_t      occupancy;

  // ------------------------------------------------------------------------
  // frame count
  // ------------------------------------------------------------------------

  // store and send together cancel out
  always_comb begin
    frame_cnt_nxt = frame_cnt;
    if (frame_stored && !frame_sent) begin
      frame_cnt_nxt = frame_cnt + 1'b1;
    end else if (frame_sent && !frame_stored) begin
      frame_cnt_nxt = frame_cnt - 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // occupancy
  // ------------------------------------------------------------------------

  // pointer difference wraps with the memory
  assign occ_raw = wr_addr - rd_addr;

  // read pointer briefly ahead after a frame's tail, treat as empty
  assign occupancy = (occ_raw >= tx_fifo_pkg::addr_t'(tx_fifo_pkg::DEPTH - tx_fifo_pkg::RD_LEAD))
                     ? '0 : occ_raw;

  // everything registered, one cycle behind its cause
  always_ff @(posedge wr_clk) begin
    if (wr_sreset) begin
      frame_cnt      <= '0;
      frame_in_fifo  <= 1'b0;
      fifo_full      <= 1'b0;
      wr_fifo_status <= '0;
    end else begin
      frame_cnt     <= frame_cnt_nxt;
      frame_in_fifo <= (frame_cnt_nxt != '0);
      // free entries below the margin
      fifo_full <= (occupancy >
                    tx_fifo_pkg::addr_t'(tx_fifo_pkg::DEPTH - tx_fifo_pkg::FULL_MARGIN));
      // top bits give sixteenths
      wr_fifo_status <= occupancy[tx_fifo_pkg::ADDR_W-1 -: tx_fifo_pkg::STATUS_W];
    end
  end

  // reader never releases a frame the writer has not committed
  a_no_underflow: assert property (@(posedge wr_clk) disable iff (wr_sreset)
    (frame_sent && !frame_stored) |-> (frame_cnt != '0));

endmodule

// ==== logic/tx_client_fifo.sv ====
// Ethernet MAC transmit client FIFO
// top level

`timescale 1ns/1ns

module tx_client_fifo (
  // local-link side
  input  logic                             wr_clk,
  input  logic                             wr_sreset,
  input  tx_fifo_pkg::byte_t               wr_data,
  input  logic                             wr_sof_n,
  input  logic                             wr_eof_n,
  input  logic                             wr_src_rdy_n,
  output logic                             wr_dst_rdy_n,
  output logic [tx_fifo_pkg::STATUS_W-1:0] wr_fifo_status,
  // MAC side
  input  logic                             rd_enable,
  output tx_fifo_pkg::byte_t               tx_data,
  output logic                             tx_data_valid,
  input  logic                             tx_ack,
  output logic                             overflow
);

  // memory ports
  logic                wr_en;
  tx_fifo_pkg::addr_t  wr_addr;
  tx_fifo_pkg::entry_t wr_entry;
  logic                rd_en;
  tx_fifo_pkg::addr_t  rd_addr;
  tx_fifo_pkg::entry_t rd_entry;

  // frame accounting
  logic                frame_stored;
  logic                frame_sent;
  logic                frame_in_fifo;
  logic                fifo_full;

  frame_writer u_writer (
    .wr_clk        (wr_clk),
    .wr_sreset     (wr_sreset),
    .wr_data       (wr_data),
    .wr_sof_n      (wr_sof_n),
    .wr_eof_n      (wr_eof_n),
    .wr_src_rdy_n  (wr_src_rdy_n),
    .fifo_full     (fifo_full),
    .frame_in_fifo (frame_in_fifo),
    .wr_dst_rdy_n  (wr_dst_rdy_n),
    .overflow      (overflow),
    .wr_en         (wr_en),
    .frame_stored  (frame_stored),
    .wr_addr       (wr_addr),
    .wr_entry      (wr_entry)
  );

  frame_store_ram u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .wr_addr  (wr_addr),
    .rd_addr  (rd_addr),
    .wr_entry (wr_entry),
    .rd_entry (rd_entry)
  );

  frame_reader u_reader (
    .wr_clk        (wr_clk),
    .wr_sreset     (wr_sreset),
    .rd_enable     (rd_enable),
    .tx_ack        (tx_ack),
    .frame_in_fifo (frame_in_fifo),
    .rd_entry      (rd_entry),
    .rd_en         (rd_en),
    .frame_sent    (frame_sent),
    .tx_data_valid (tx_data_valid),
    .rd_addr       (rd_addr),
    .tx_data       (tx_data)
  );

  occupancy_tracker u_tracker (
    .wr_clk         (wr_clk),
    .wr_sreset      (wr_sreset),
    .frame_stored   (frame_stored),
    .frame_sent     (frame_sent),
    .wr_addr        (wr_addr),
    .rd_addr        (rd_addr),
    .frame_in_fifo  (frame_in_fifo),
    .fifo_full      (fifo_full),
    .wr_fifo_status (wr_fifo_status)
  );

endmodule

// ==== logic/tx_fifo_pkg.sv ====
// Transmit client FIFO
// shared widths, thresholds and state encodings

package tx_fifo_pkg;

  // ------------------------------------------------------------------------
  // memory geometry
  // ------------------------------------------------------------------------

  localparam int ADDR_W = 9;
  localparam int DEPTH = 1 << ADDR_W;
  localparam int DATA_W = 8;

  // fewer free entries than this and the writer stalls
  localparam int FULL_MARGIN = 16;

  // status reports occupancy in sixteenths of the memory
  localparam int STATUS_W = 4;

  // read prefetch runs past the last stored entry by at most two,
  // so a wrapped difference this close to DEPTH means an empty memory
  localparam int RD_LEAD = 4;

  // ------------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------------

  // memory address, also used for occupancy
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [DATA_W-1:0] byte_t;

  // stored entry, end-of-frame flag above the data byte
  typedef logic [DATA_W:0] entry_t;

  // one spare bit so a memory full of minimum frames still counts
  typedef logic [ADDR_W:0] frame_cnt_t;

  // write side FSM
  typedef enum logic [1:0] {
    WAIT_S   = 2'b00,
    DATA_S   = 2'b01,
    EOF_S    = 2'b10,
    OVFLOW_S = 2'b11
  } wr_state_t;

  // read side FSM
  typedef enum logic [2:0] {
    IDLE_S      = 3'd0,
    QUEUE1_S    = 3'd1,
    QUEUE2_S    = 3'd2,
    QUEUE3_S    = 3'd3,
    QUEUE_ACK_S = 3'd4,
    WAIT_ACK_S  = 3'd5,
    FRAME_S     = 3'd6
  } rd_state_t;

endpackage

// ==== project.f ====
+incdir+bench
logic/tx_fifo_pkg.sv
logic/frame_writer.sv
logic/frame_store_ram.sv
logic/frame_reader.sv
logic/occupancy_tracker.sv
logic/tx_client_fifo.sv
bench/tb_tx_client_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the transmit client FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f project.f --top-module tb_tx_client_fifo -o sim_tx_client_fifo

# keep the exit code so the log can still be searched
status=0
./obj_dir/sim_tx_client_fifo > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
  echo "testbench reported failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation stopped with status $status"
  exit 1
fi
echo "no failure in sim.log"
